// File: compile.f
+incdir+verification
logic/cpu_pkg.sv
logic/fetch.sv
logic/stage_reg.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/hazard_unit.sv
logic/top.sv
verification/cpu_tb.sv

// File: Makefile
TOP := cpu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f compile.f --top-module $(TOP)

run: build
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module top

clean:
	rm -rf obj_dir

// File: verification/rv_ref_model.svh
typedef logic [31:0] word_q_t[$];

function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
    endcase
endfunction

// runs the rom one instruction at a time, lists each new a0 value.
function automatic word_q_t model_a0_trace();
    logic [31:0] x [32];
    logic [7:0]  mem [cpu_pkg::dmem_words * 4];
    word_q_t     trace;
    logic [31:0] pc, ins, a, b, res, nxt, addr, last;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic        wr;
    int          base;
    foreach (x[i])
        x[i] = '0;
    foreach (mem[i])
        mem[i] = '0;
    pc   = '0;
    last = '0; // a0 leaves reset at zero.
    for (int step = 0; step < 10000; step++) begin
        ins   = cpu_pkg::program_rom[int'(pc >> 2) % cpu_pkg::imem_words];
        op    = ins[6:0];
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = x[ins[19:15]];
        b     = x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'd0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        if (op == cpu_pkg::op_jal && imm_j == 32'd0)
            break; // self loop reached.
        nxt = pc + 32'd4;
        res = '0;
        wr  = 1'b0;
        case (op)
            cpu_pkg::op_lui: begin
                res = imm_u;
                wr  = 1'b1;
            end
            cpu_pkg::op_auipc: begin
                res = pc + imm_u;
                wr  = 1'b1;
            end
            cpu_pkg::op_jal: begin
                res = pc + 32'd4;
                nxt = pc + imm_j;
                wr  = 1'b1;
            end
            cpu_pkg::op_jalr: begin
                res = pc + 32'd4;
                nxt = (a + imm_i) & ~32'd1;
                wr  = 1'b1;
            end
            cpu_pkg::op_branch: begin
                if (ref_branch(f3, a, b))
                    nxt = pc + imm_b;
            end
            cpu_pkg::op_load: begin
                addr = a + imm_i;
                base = int'(addr % (cpu_pkg::dmem_words * 4));
                case (f3)
                    3'b000:  res = {{24{mem[base][7]}}, mem[base]};
                    3'b001:  res = {{16{mem[base+1][7]}}, mem[base+1], mem[base]};
                    3'b100:  res = {24'd0, mem[base]};
                    3'b101:  res = {16'd0, mem[base+1], mem[base]};
                    default: res = {mem[base+3], mem[base+2], mem[base+1], mem[base]};
                endcase
                wr = 1'b1;
            end
            cpu_pkg::op_store: begin
                addr      = a + imm_s;
                base      = int'(addr % (cpu_pkg::dmem_words * 4));
                mem[base] = b[7:0];
                if (f3[1:0] != 2'b00)
                    mem[base+1] = b[15:8];
                if (f3[1:0] == 2'b10) begin
                    mem[base+2] = b[23:16];
                    mem[base+3] = b[31:24];
                end
            end
            cpu_pkg::op_imm: begin
                res = ref_alu(f3, f3 == 3'b101 && ins[30], a, imm_i);
                wr  = 1'b1;
            end
            cpu_pkg::op_reg: begin
                res = ref_alu(f3, ins[30], a, b);
                wr  = 1'b1;
            end
            default: ;
        endcase
        if (wr && rd != 5'd0)
            x[rd] = res;
        if (wr && rd == 5'd10 && res !== last) begin
            trace.push_back(res);
            last = res;
        end
        pc = nxt;
    end
    return trace;
endfunction

// File: verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    `include "rv_ref_model.svh"

    logic        clk;
    logic        reset;
    logic        trigger;
    logic [31:0] a0;

    logic [31:0] changes [$];
    word_q_t     expected;
    logic [31:0] prev_a0;
    logic [31:0] marker_val;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    bit          timed_out;

    top dut_i (
        .clk(clk),
        .reset(reset),
        .trigger(trigger),
        .a0(a0)
    );

    always #5 clk = ~clk;

    // a0 is sampled at the falling edge, halfway between updates.
    always @(negedge clk) begin
        if (!reset && a0 !== prev_a0) begin
            changes.push_back(a0);
            prev_a0 = a0;
        end
    end

    task automatic check_value(input string what, input logic [31:0] exp_val,
                               input logic [31:0] got);
        if (exp_val !== got) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, what, exp_val, got);
            errors++;
        end
    endtask

    task automatic wait_changes(input int count, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (changes.size() < count && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (changes.size() < count) begin
            $display("timeout: %s not seen on a0 within %0d cycles", what, limit);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic compare_range(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            if (i >= expected.size()) begin
                $display("reference model produced no checkpoint %0d", i + 1);
                errors++;
            end else begin
                check_value($sformatf("checkpoint %0d", i + 1), expected[i], changes[i]);
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail", name);
        end
    endtask

    task automatic run_behaviors();
        int mark;
        mark = errors;
        repeat (20) @(posedge clk);
        #1;
        check_value("a0 before trigger", 32'd0, a0);
        check_value("a0 changes before trigger", 32'd0, changes.size());
        report_test("1 idle before trigger", mark);

        trigger = 1'b1; // one cycle pulse.
        @(posedge clk);
        #1 trigger = 1'b0;

        mark = errors;
        wait_changes(3, 200, "checkpoint 3");
        if (!timed_out)
            compare_range(0, 2);
        report_test("2 alu and forwarding", mark);
        if (timed_out)
            return;

        mark = errors;
        wait_changes(6, 200, "checkpoint 6");
        if (!timed_out)
            compare_range(3, 5);
        report_test("3 loads and stores", mark);
        if (timed_out)
            return;

        mark = errors;
        wait_changes(9, 200, "checkpoint 9");
        if (!timed_out)
            compare_range(6, 8);
        foreach (changes[i]) begin
            if (changes[i] === marker_val) begin
                $display("wrong-path marker %h reached a0 at change %0d", marker_val, i + 1);
                errors++;
            end
        end
        report_test("4 branches and jumps", mark);
        if (timed_out)
            return;

        mark = errors;
        wait_changes(expected.size(), 200, "last model value");
        if (!timed_out) begin
            repeat (50) @(posedge clk); // a0 must hold in the final loop.
            #1;
            check_value("a0 change count", expected.size(), changes.size());
            if (expected.size() > 0)
                check_value("final a0", expected[expected.size() - 1], a0);
        end
        report_test("5 final loop", mark);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        trigger      = 1'b0;
        prev_a0      = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        expected     = model_a0_trace();
        marker_val   = {{20{cpu_pkg::marker[31]}}, cpu_pkg::marker[31:20]};
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        run_behaviors();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: logic/top.sv
`timescale 1ns/1ps

module top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     trigger,
    output logic [cpu_pkg::xlen-1:0] a0
);

    cpu_pkg::fd_t fd_f, fd_d;
    cpu_pkg::de_t de_d, de_e;
    cpu_pkg::em_t em_e, em_m;
    cpu_pkg::mw_t mw_m, mw_w;

    logic                     redirect;
    logic [cpu_pkg::xlen-1:0] redirect_pc;
    logic [4:0]               d_rs1, d_rs2;
    logic [1:0]               fwd_a, fwd_b;
    logic                     stall_f, stall_d, flush_d, flush_e;

    fetch fetch_i (
        .clk(clk),
        .reset(reset),
        .trigger(trigger),
        .stall(stall_f),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .fd(fd_f)
    );

    stage_reg #(.payload_t(cpu_pkg::fd_t)) fd_reg (
        .clk(clk), .reset(reset), .stall(stall_d), .flush(flush_d), .d(fd_f), .q(fd_d)
    );

    decode decode_i (
        .clk(clk),
        .reset(reset),
        .fd(fd_d),
        .wb(mw_w),
        .de(de_d),
        .rs1(d_rs1),
        .rs2(d_rs2),
        .a0(a0)
    );

    stage_reg #(.payload_t(cpu_pkg::de_t)) de_reg (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(flush_e), .d(de_d), .q(de_e)
    );

    execute execute_i (
        .de(de_e),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .m_value(em_m.alu_result),
        .w_value(mw_w.result),
        .em(em_e),
        .redirect(redirect),
        .redirect_pc(redirect_pc)
    );

    stage_reg #(.payload_t(cpu_pkg::em_t)) em_reg (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(em_e), .q(em_m)
    );

    memory memory_i (
        .clk(clk),
        .em(em_m),
        .mw(mw_m)
    );

    stage_reg #(.payload_t(cpu_pkg::mw_t)) mw_reg (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(mw_m), .q(mw_w)
    );

    hazard_unit hazard_i (
        .e_rs1(de_e.rs1),
        .e_rs2(de_e.rs2),
        .d_rs1(d_rs1),
        .d_rs2(d_rs2),
        .e_mem_read(de_e.mem_read),
        .e_rd(de_e.rd),
        .m_rd(em_m.rd),
        .w_rd(mw_w.rd),
        .m_reg_write(em_m.reg_write),
        .w_reg_write(mw_w.reg_write),
        .redirect(redirect),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .stall_f(stall_f),
        .stall_d(stall_d),
        .flush_d(flush_d),
        .flush_e(flush_e)
    );

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic [4:0] e_rs1,
    input  logic [4:0] e_rs2,
    input  logic [4:0] d_rs1,
    input  logic [4:0] d_rs2,
    input  logic       e_mem_read,
    input  logic [4:0] e_rd,
    input  logic [4:0] m_rd,
    input  logic [4:0] w_rd,
    input  logic       m_reg_write,
    input  logic       w_reg_write,
    input  logic       redirect,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b,
    output logic       stall_f,
    output logic       stall_d,
    output logic       flush_d,
    output logic       flush_e
);

    logic load_use;

    function automatic logic [1:0] fwd_sel(logic [4:0] rs);
        if (rs == 5'd0)
            return cpu_pkg::fwd_reg;
        if (m_reg_write && m_rd == rs)
            return cpu_pkg::fwd_m; // youngest wins.
        if (w_reg_write && w_rd == rs)
            return cpu_pkg::fwd_w;
        return cpu_pkg::fwd_reg;
    endfunction

    assign fwd_a = fwd_sel(e_rs1);
    assign fwd_b = fwd_sel(e_rs2);

    assign load_use = e_mem_read && (e_rd != 5'd0) && (e_rd == d_rs1 || e_rd == d_rs2);

    assign stall_f = load_use;
    assign stall_d = load_use;
    assign flush_d = redirect;
    assign flush_e = redirect || load_use; // bubble into e.

endmodule

// File: logic/memory.sv
`timescale 1ns/1ps

module memory (
    input  logic         clk,
    input  cpu_pkg::em_t em,
    output cpu_pkg::mw_t mw
);

    localparam int aw = $clog2(cpu_pkg::dmem_words);

    logic [31:0]   ram [cpu_pkg::dmem_words];
    logic [aw-1:0] word;
    logic [1:0]    offs;
    logic [31:0]   rdata, shifted, load_val, wdata;
    logic [3:0]    be;

    assign word    = em.alu_result[aw+1:2];
    assign offs    = em.alu_result[1:0];
    assign rdata   = ram[word];
    assign shifted = rdata >> {offs, 3'b000};

    always_comb begin
        case (em.funct3[1:0])
            2'b00:   begin be = 4'b0001 << offs;   wdata = {4{em.store_data[7:0]}}; end
            2'b01:   begin be = 4'b0011 << offs;   wdata = {2{em.store_data[15:0]}}; end
            default: begin be = 4'b1111;           wdata = em.store_data; end
        endcase
    end

    always_ff @(posedge clk) begin
        if (em.valid && em.mem_write) begin
            for (int i = 0; i < 4; i++)
                if (be[i])
                    ram[word][i*8 +: 8] <= wdata[i*8 +: 8];
        end
    end

    always_comb begin
        case (em.funct3)
            3'b000:  load_val = {{24{shifted[7]}}, shifted[7:0]};
            3'b001:  load_val = {{16{shifted[15]}}, shifted[15:0]};
            3'b100:  load_val = {24'd0, shifted[7:0]};
            3'b101:  load_val = {16'd0, shifted[15:0]};
            default: load_val = rdata;
        endcase
    end

    always_comb begin
        mw.valid     = em.valid;
        mw.result    = em.mem_read ? load_val : em.alu_result; // final writeback value.
        mw.rd        = em.rd;
        mw.reg_write = em.reg_write;
    end

endmodule

// File: logic/execute.sv
`timescale 1ns/1ps

module execute (
    input  cpu_pkg::de_t             de,
    input  logic [1:0]               fwd_a,
    input  logic [1:0]               fwd_b,
    input  logic [cpu_pkg::xlen-1:0] m_value,
    input  logic [cpu_pkg::xlen-1:0] w_value,
    output cpu_pkg::em_t             em,
    output logic                     redirect,
    output logic [cpu_pkg::xlen-1:0] redirect_pc
);

    logic [cpu_pkg::xlen-1:0] a, b, op_a, op_b, alu;
    logic                     taken;

    function automatic logic [cpu_pkg::xlen-1:0] pick(logic [1:0] sel,
                                                      logic [cpu_pkg::xlen-1:0] r,
                                                      logic [cpu_pkg::xlen-1:0] m,
                                                      logic [cpu_pkg::xlen-1:0] w);
        case (sel)
            cpu_pkg::fwd_m: return m;
            cpu_pkg::fwd_w: return w;
            default:        return r;
        endcase
    endfunction

    assign a    = pick(fwd_a, de.rs1_val, m_value, w_value);
    assign b    = pick(fwd_b, de.rs2_val, m_value, w_value);
    assign op_a = de.alu_src_a_pc ? de.pc : a;
    assign op_b = de.alu_src_b_imm ? de.imm : b;

    always_comb begin
        case (de.alu_op)
            cpu_pkg::alu_sub:    alu = op_a - op_b;
            cpu_pkg::alu_sll:    alu = op_a << op_b[4:0];
            cpu_pkg::alu_slt:    alu = {31'd0, $signed(op_a) < $signed(op_b)};
            cpu_pkg::alu_sltu:   alu = {31'd0, op_a < op_b};
            cpu_pkg::alu_xor:    alu = op_a ^ op_b;
            cpu_pkg::alu_srl:    alu = op_a >> op_b[4:0];
            cpu_pkg::alu_sra:    alu = $unsigned($signed(op_a) >>> op_b[4:0]);
            cpu_pkg::alu_or:     alu = op_a | op_b;
            cpu_pkg::alu_and:    alu = op_a & op_b;
            cpu_pkg::alu_pass_b: alu = op_b;
            default:             alu = op_a + op_b;
        endcase
    end

    always_comb begin
        case (de.funct3)
            3'b000:  taken = a == b;
            3'b001:  taken = a != b;
            3'b100:  taken = $signed(a) < $signed(b);
            3'b101:  taken = $signed(a) >= $signed(b);
            3'b110:  taken = a < b;
            default: taken = a >= b;
        endcase
    end

    assign redirect    = de.valid && (de.jump || (de.branch && taken));
    assign redirect_pc = de.jalr ? ((a + de.imm) & ~32'd1) : de.pc + de.imm;

    always_comb begin
        em.valid      = de.valid;
        em.alu_result = de.jump ? de.pc + 32'd4 : alu; // link value.
        em.store_data = b;
        em.rd         = de.rd;
        em.funct3     = de.funct3;
        em.reg_write  = de.reg_write;
        em.mem_read   = de.mem_read;
        em.mem_write  = de.mem_write;
    end

endmodule

// File: logic/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_pkg::fd_t             fd,
    input  cpu_pkg::mw_t             wb,
    output cpu_pkg::de_t             de,
    output logic [4:0]               rs1,
    output logic [4:0]               rs2,
    output logic [cpu_pkg::xlen-1:0] a0
);

    logic [cpu_pkg::xlen-1:0] regs [1:31];
    logic [31:0]              instr;
    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic                     funct7_b5;
    logic                     wb_en;

    assign instr     = fd.instr;
    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign wb_en     = wb.valid && wb.reg_write && (wb.rd != 5'd0);
    assign a0        = regs[10];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_en) begin
            regs[wb.rd] <= wb.result;
        end
    end

    function automatic logic [cpu_pkg::xlen-1:0] read_reg(logic [4:0] idx);
        if (idx == 5'd0)
            return '0;
        if (wb_en && wb.rd == idx)
            return wb.result; // write-through.
        return regs[idx];
    endfunction

    function automatic cpu_pkg::alu_op_t alu_decode(logic [2:0] f3, logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
            3'b001:  return cpu_pkg::alu_sll;
            3'b010:  return cpu_pkg::alu_slt;
            3'b011:  return cpu_pkg::alu_sltu;
            3'b100:  return cpu_pkg::alu_xor;
            3'b101:  return sub_sra ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
            3'b110:  return cpu_pkg::alu_or;
            default: return cpu_pkg::alu_and;
        endcase
    endfunction

    always_comb begin
        de         = '0;
        de.valid   = fd.valid;
        de.pc      = fd.pc;
        de.rs1     = rs1;
        de.rs2     = rs2;
        de.rd      = instr[11:7];
        de.rs1_val = read_reg(rs1);
        de.rs2_val = read_reg(rs2);
        de.funct3  = funct3;
        de.imm     = {{20{instr[31]}}, instr[31:20]}; // i-type by default.
        if (fd.valid) begin
            case (opcode)
                cpu_pkg::op_lui: begin
                    de.imm           = {instr[31:12], 12'd0};
                    de.alu_op        = cpu_pkg::alu_pass_b;
                    de.alu_src_b_imm = 1'b1;
                    de.reg_write     = 1'b1;
                end
                cpu_pkg::op_auipc: begin
                    de.imm           = {instr[31:12], 12'd0};
                    de.alu_src_a_pc  = 1'b1;
                    de.alu_src_b_imm = 1'b1;
                    de.reg_write     = 1'b1;
                end
                cpu_pkg::op_jal: begin
                    de.imm       = {{12{instr[31]}}, instr[19:12], instr[20],
                                    instr[30:21], 1'b0};
                    de.jump      = 1'b1;
                    de.reg_write = 1'b1;
                end
                cpu_pkg::op_jalr: begin
                    de.jump      = 1'b1;
                    de.jalr      = 1'b1;
                    de.reg_write = 1'b1;
                end
                cpu_pkg::op_branch: begin
                    de.imm    = {{20{instr[31]}}, instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
                    de.branch = 1'b1;
                end
                cpu_pkg::op_load: begin
                    de.alu_src_b_imm = 1'b1;
                    de.mem_read      = 1'b1;
                    de.reg_write     = 1'b1;
                end
                cpu_pkg::op_store: begin
                    de.imm           = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    de.alu_src_b_imm = 1'b1;
                    de.mem_write     = 1'b1;
                end
                cpu_pkg::op_imm: begin
                    de.alu_op        = alu_decode(funct3, funct3 == 3'b101 && funct7_b5);
                    de.alu_src_b_imm = 1'b1;
                    de.reg_write     = 1'b1;
                end
                cpu_pkg::op_reg: begin
                    de.alu_op    = alu_decode(funct3, funct7_b5);
                    de.reg_write = 1'b1;
                end
                default: de.valid = 1'b0; // unsupported, treat as bubble.
            endcase
        end
    end

endmodule

// File: logic/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset || flush)
            q <= '0; // bubble.
        else if (!stall)
            q <= d;
    end

endmodule

// File: logic/fetch.sv
`timescale 1ns/1ps

module fetch (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      trigger,
    input  logic                      stall,
    input  logic                      redirect,
    input  logic [cpu_pkg::xlen-1:0]  redirect_pc,
    output cpu_pkg::fd_t              fd
);

    localparam int aw = $clog2(cpu_pkg::imem_words);

    logic [cpu_pkg::xlen-1:0] pc;
    logic                     run;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc  <= '0;
            run <= 1'b0;
        end else begin
            if (trigger)
                run <= 1'b1;
            if (redirect)
                pc <= redirect_pc;
            else if (run && !stall)
                pc <= pc + 32'd4;
        end
    end

    always_comb begin
        fd.valid = run;
        fd.pc    = pc;
        fd.instr = cpu_pkg::program_rom[pc[aw+1:2]]; // word addressed rom.
    end

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int imem_words = 64;
    localparam int dmem_words = 64;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    localparam logic [1:0] fwd_reg = 2'd0; // value read in decode.
    localparam logic [1:0] fwd_m   = 2'd1;
    localparam logic [1:0] fwd_w   = 2'd2;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     instr;
    } fd_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
        alu_op_t         alu_op;
        logic            alu_src_a_pc;
        logic            alu_src_b_imm;
        logic            branch;
        logic            jump;
        logic            jalr;
        logic [2:0]      funct3;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
    } de_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] store_data;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
    } em_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] result;
        logic [4:0]      rd;
        logic            reg_write;
    } mw_t;

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    localparam logic [31:0] marker = enc_i(12'h777, 5'd0, 3'b000, 5'd10, op_imm);

    localparam logic [31:0] program_rom [imem_words] = '{
        0:  enc_i(12'd5, 5'd0, 3'b000, 5'd1, op_imm),
        1:  enc_i(12'd7, 5'd1, 3'b000, 5'd2, op_imm),
        2:  enc_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd3, op_reg),
        3:  enc_r(7'd0, 5'd2, 5'd3, 3'b000, 5'd10, op_reg), // checkpoint 1.
        4:  enc_u(20'h12345, 5'd4, op_lui),
        5:  enc_i(12'h678, 5'd4, 3'b100, 5'd5, op_imm),
        6:  enc_i(12'h404, 5'd5, 3'b101, 5'd6, op_imm),      // srai by 4.
        7:  enc_r(7'd0, 5'd3, 5'd6, 3'b110, 5'd10, op_reg), // checkpoint 2.
        8:  enc_r(7'd0, 5'd2, 5'd1, 3'b011, 5'd7, op_reg),
        9:  enc_r(7'd0, 5'd7, 5'd5, 3'b001, 5'd8, op_reg),
        10: enc_r(7'd0, 5'd0, 5'd8, 3'b010, 5'd9, op_reg),
        11: enc_r(7'd0, 5'd9, 5'd8, 3'b000, 5'd10, op_reg), // checkpoint 3.
        12: enc_s(12'd0, 5'd5, 5'd0, 3'b010),
        13: enc_i(12'd0, 5'd0, 3'b010, 5'd12, op_load),
        14: enc_i(12'd1, 5'd12, 3'b000, 5'd10, op_imm),     // load-use, checkpoint 4.
        15: enc_i(12'hf80, 5'd0, 3'b000, 5'd13, op_imm),
        16: enc_s(12'd4, 5'd13, 5'd0, 3'b000),
        17: enc_s(12'd6, 5'd5, 5'd0, 3'b001),
        18: enc_i(12'd4, 5'd0, 3'b000, 5'd14, op_load),
        19: enc_i(12'd4, 5'd0, 3'b100, 5'd15, op_load),
        20: enc_r(7'd0, 5'd15, 5'd14, 3'b100, 5'd10, op_reg), // checkpoint 5.
        21: enc_i(12'd2, 5'd0, 3'b001, 5'd16, op_load),
        22: enc_i(12'd6, 5'd0, 3'b101, 5'd17, op_load),
        23: enc_r(7'd0, 5'd17, 5'd16, 3'b000, 5'd10, op_reg), // checkpoint 6.
        24: enc_b(13'd8, 5'd1, 5'd1, 3'b000),
        25: marker,
        26: enc_i(12'd7, 5'd0, 3'b000, 5'd10, op_imm),      // checkpoint 7.
        27: enc_b(13'd8, 5'd1, 5'd1, 3'b001),                // not taken.
        28: enc_b(13'd8, 5'd1, 5'd14, 3'b100),
        29: marker,
        30: enc_b(13'd8, 5'd1, 5'd14, 3'b111),
        31: marker,
        32: enc_j(21'd8, 5'd18),
        33: marker,
        34: enc_i(12'd0, 5'd18, 3'b000, 5'd10, op_imm),     // checkpoint 8.
        35: enc_u(20'd0, 5'd19, op_auipc),
        36: enc_i(12'd16, 5'd19, 3'b000, 5'd20, op_jalr),
        37: marker,
        38: marker,
        39: enc_i(12'd1, 5'd20, 3'b000, 5'd10, op_imm),     // checkpoint 9.
        40: enc_j(21'd0, 5'd0),                              // final self loop.
        default: enc_i(12'd0, 5'd0, 3'b000, 5'd0, op_imm)
    };

endpackage
